//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it, and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_usb_audio -Mdir obj_dir -f flist.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_usb_audio > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "TESTS FAILED" "$SIM_LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0

//--- flist.f
audio_cfg_pkg.sv
audio_types_pkg.sv
sample_tick_gen.sv
pcm_deframer.sv
pcm_fifo.sv
pcm_player.sv
pcm_packetizer.sv
usb_audio_top.sv
tb_usb_audio.sv

//--- tb_usb_audio.sv
/*
 * testbench for the usb audio streaming top level
 * clock and reset, random OUT bytes and microphone samples,
 * playback and capture reference queues, self checks
 */
`default_nettype none

module tb_usb_audio;
    timeunit 1ns;
    timeprecision 100ps;

    import audio_types_pkg::*;

    localparam int TICK_PERIOD = 1250;                   // 60 MHz / 48 kHz
    localparam int PKT_BYTES   = 192;                    // 48 frames of 4 bytes
    localparam int CAP_DEPTH   = 512;                    // capture buffer frames
    localparam int PKT_LIMIT   = 4000;                   // cycles allowed for one packet

    logic        clk;
    logic        usb_rstn;
    logic        i_sof;
    out_stream_t i_out;
    logic        i_in_ready;
    pcm_sample_t i_audio_l;
    pcm_sample_t i_audio_r;
    wire         o_audio_en;
    wire pcm_sample_t o_audio_l;
    wire pcm_sample_t o_audio_r;
    wire usb_byte_t   o_in_data;
    wire         o_in_valid;

    pcm_frame_t  play_q [$];                             // frames expected on the speaker
    pcm_frame_t  cap_q [$];                              // frames expected in IN packets
    pcm_frame_t  last_played;

    usb_audio_top dut0 (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .i_sof      (i_sof),
        .i_out      (i_out),
        .i_in_ready (i_in_ready),
        .i_audio_l  (i_audio_l),
        .i_audio_r  (i_audio_r),
        .o_audio_en (o_audio_en),
        .o_audio_l  (o_audio_l),
        .o_audio_r  (o_audio_r),
        .o_in_data  (o_in_data),
        .o_in_valid (o_in_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                          // 100 ns period
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // returns the number of falling edges until the tick is seen
    task automatic wait_tick(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!o_audio_en && cycles < 2 * TICK_PERIOD);
        if (!o_audio_en) abort_run("timeout waiting for the sample tick");
    endtask

    task automatic send_byte(input usb_byte_t b, input int gap);
        i_out = '{valid: 1'b1, data: b};
        @(negedge clk);
        i_out.valid = 1'b0;
        repeat (gap) begin
            i_out.data = usb_byte_t'($urandom);           // junk while idle
            @(negedge clk);
        end
    endtask

    // wire order is left low, left high, right low, right high
    task automatic send_frame(input int max_gap);
        usb_byte_t  b [4];
        pcm_frame_t f;
        for (int i = 0; i < 4; i++) begin
            b[i] = usb_byte_t'($urandom);
            send_byte(b[i], $urandom_range(0, max_gap));
        end
        f.left  = {b[1], b[0]};
        f.right = {b[3], b[2]};
        play_q.push_back(f);
    endtask

    function automatic usb_byte_t expected_in_byte(input pcm_frame_t f, input int idx);
        case (idx)
            0:       return f.left[7:0];
            1:       return f.left[15:8];
            2:       return f.right[7:0];
            default: return f.right[15:8];
        endcase
    endfunction

    // new mic sample on every tick, pushed by the DUT on the next rising edge
    initial begin : mic_model
        pcm_frame_t mic;
        forever begin
            @(negedge clk);
            if (o_audio_en) begin
                i_audio_l = pcm_sample_t'($urandom);
                i_audio_r = pcm_sample_t'($urandom);
                mic.left  = i_audio_l;
                mic.right = i_audio_r;
                if (cap_q.size() < CAP_DEPTH) cap_q.push_back(mic);
            end
        end
    end

    initial begin : watchdog
        repeat (250_000) @(posedge clk);
        abort_run("simulation ran past its cycle limit");
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin : main_seq
        int   cycles;
        int   accepted;
        int   waited;
        logic rdy;
        void'($urandom(32'hed73_156e));
        usb_rstn    = 1'b0;
        i_sof       = 1'b0;
        i_out       = '0;
        i_in_ready  = 1'b0;
        i_audio_l   = '0;
        i_audio_r   = '0;
        last_played = '0;

        repeat (10) @(negedge clk);
        usb_rstn = 1'b1;
        check_value("o_audio_en", {31'h0, o_audio_en}, 32'h0);
        check_value("o_in_valid", {31'h0, o_in_valid}, 32'h0);
        check_value("o_audio_l", {16'h0, o_audio_l}, 32'h0);
        check_value("o_audio_r", {16'h0, o_audio_r}, 32'h0);

        // first pulse and ten full periods
        wait_tick(cycles);
        check_value("o_audio_en period", cycles, TICK_PERIOD);
        repeat (10) begin
            wait_tick(cycles);
            check_value("o_audio_en period", cycles, TICK_PERIOD);
        end

        // playback, 20 frames then two underrun ticks
        for (int f = 0; f < 20; f++) send_frame(3);
        for (int k = 0; k < 22; k++) begin
            wait_tick(cycles);
            @(negedge clk);                              // outputs update after the tick
            if (play_q.size() > 0) last_played = play_q.pop_front();
            check_value("o_audio_l", {16'h0, o_audio_l}, {16'h0, last_played.left});
            check_value("o_audio_r", {16'h0, o_audio_r}, {16'h0, last_played.right});
        end

        // two stray bytes, then sof drops them and opens the first IN packet
        send_byte(usb_byte_t'($urandom), 0);
        send_byte(usb_byte_t'($urandom), 0);
        check_value("o_in_valid", {31'h0, o_in_valid}, 32'h0);   // no sof seen yet
        i_sof = 1'b1;
        @(negedge clk);
        i_sof = 1'b0;
        check_value("o_in_valid", {31'h0, o_in_valid}, 32'h1);   // rises after sof
        send_frame(0);
        wait_tick(cycles);
        @(negedge clk);
        last_played = play_q.pop_front();
        check_value("o_audio_l", {16'h0, o_audio_l}, {16'h0, last_played.left});
        check_value("o_audio_r", {16'h0, o_audio_r}, {16'h0, last_played.right});

        // capture, one IN packet under random back-pressure
        repeat (60) wait_tick(cycles);
        i_sof = 1'b1;
        @(negedge clk);
        i_sof = 1'b0;
        accepted = 0;
        waited   = 0;
        while (accepted < PKT_BYTES) begin
            check_value("o_in_valid", {31'h0, o_in_valid}, 32'h1);
            rdy        = ($urandom_range(0, 3) != 0);    // ready about 3 of 4 cycles
            i_in_ready = rdy;
            if (rdy) begin
                check_value("o_in_data", {24'h0, o_in_data},
                            {24'h0, expected_in_byte(cap_q[0], accepted % 4)});
                if (accepted % 4 == 3) void'(cap_q.pop_front());
                accepted++;
            end
            @(negedge clk);
            waited++;
            if (waited > PKT_LIMIT) abort_run("timeout waiting for the IN packet bytes");
        end
        i_in_ready = 1'b0;
        check_value("o_in_valid", {31'h0, o_in_valid}, 32'h0);   // packet closed

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- usb_audio_top.sv
/*
 * usb audio streaming top level
 * sample tick, OUT deframer, playback buffer, capture packetizer
 */
`default_nettype none

module usb_audio_top (
    input  wire                               clk,               // 60 MHz
    input  wire                               usb_rstn,
    input  wire                               i_sof,             // 1 ms frame start
    input  wire audio_types_pkg::out_stream_t i_out,             // host-to-device bytes
    input  wire                               i_in_ready,
    input  wire audio_types_pkg::pcm_sample_t i_audio_l,         // microphone left
    input  wire audio_types_pkg::pcm_sample_t i_audio_r,         // microphone right
    output wire                               o_audio_en,        // 48 kHz tick
    output wire audio_types_pkg::pcm_sample_t o_audio_l,         // speaker left
    output wire audio_types_pkg::pcm_sample_t o_audio_r,         // speaker right
    output wire audio_types_pkg::usb_byte_t   o_in_data,         // device-to-host bytes
    output wire                               o_in_valid
);
    import audio_types_pkg::*;

    pcm_frame_t frame;                                   // deframer to player
    logic       frame_valid;

    sample_tick_gen tick0 (
        .clk      (clk),
        .usb_rstn (usb_rstn),
        .o_tick   (o_audio_en)
    );

    pcm_deframer deframer0 (
        .clk           (clk),
        .usb_rstn      (usb_rstn),
        .i_sof         (i_sof),
        .i_out         (i_out),
        .o_frame       (frame),
        .o_frame_valid (frame_valid)
    );

    pcm_player player0 (
        .clk           (clk),
        .usb_rstn      (usb_rstn),
        .i_tick        (o_audio_en),
        .i_frame       (frame),
        .i_frame_valid (frame_valid),
        .o_audio_l     (o_audio_l),
        .o_audio_r     (o_audio_r)
    );

    pcm_packetizer packetizer0 (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .i_tick     (o_audio_en),
        .i_sof      (i_sof),
        .i_audio_l  (i_audio_l),
        .i_audio_r  (i_audio_r),
        .i_in_ready (i_in_ready),
        .o_in_data  (o_in_data),
        .o_in_valid (o_in_valid)
    );

endmodule

`default_nettype wire

//--- pcm_packetizer.sv
/*
 * capture stage
 * buffers one microphone frame per tick, sends a 192 byte IN packet
 * after every start-of-frame with valid/ready handshake
 */
`default_nettype none

module pcm_packetizer (
    input  wire                               clk,
    input  wire                               usb_rstn,
    input  wire                               i_tick,
    input  wire                               i_sof,
    input  wire audio_types_pkg::pcm_sample_t i_audio_l,
    input  wire audio_types_pkg::pcm_sample_t i_audio_r,
    input  wire                               i_in_ready,
    output audio_types_pkg::usb_byte_t        o_in_data,
    output logic                              o_in_valid
);
    import audio_cfg_pkg::*;
    import audio_types_pkg::*;

    pkt_state_e            state;
    logic [BYTE_IDX_W-1:0] byte_idx;                     // byte within head frame
    logic [PKT_CNT_W-1:0]  frame_cnt;                    // frames sent in this packet
    pcm_frame_t            head;
    pcm_frame_t            mic_frame;
    logic                  empty;
    logic                  full;
    logic                  push;
    logic                  pop;
    logic                  accept;                       // byte taken by the core
    logic                  last_byte;
    logic                  last_frame;

    assign mic_frame  = '{right: i_audio_r, left: i_audio_l};
    assign push       = i_tick && !full;                 // overflow drops the sample
    assign accept     = o_in_valid && i_in_ready;
    assign last_byte  = (byte_idx == BYTE_IDX_W'(BYTES_PER_FRAME - 1));
    assign last_frame = (frame_cnt == PKT_CNT_W'(FRAMES_PER_PKT - 1));
    assign pop        = accept && last_byte && !empty && !i_sof;  // underrun resends head

    assign o_in_valid = (state == PKT_SEND);
    assign o_in_data  = head[{byte_idx, 3'b000} +: 8];   // same byte order as OUT

    pcm_fifo cap_fifo (
        .clk         (clk),
        .usb_rstn    (usb_rstn),
        .i_push      (push),
        .i_push_data (mic_frame),
        .i_pop       (pop),
        .o_head      (head),
        .o_empty     (empty),
        .o_full      (full)
    );

    // ------------------------------------------------------------------------
    // packet FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            state     <= PKT_IDLE;
            byte_idx  <= '0;
            frame_cnt <= '0;
        end else if (i_sof) begin
            state     <= PKT_SEND;                       // valid rises next cycle
            byte_idx  <= '0;
            frame_cnt <= '0;
        end else begin
            case (state)
                PKT_SEND: begin
                    if (accept) begin
                        byte_idx <= byte_idx + 1'b1;     // wraps to next frame
                        if (last_byte) begin
                            frame_cnt <= frame_cnt + 1'b1;
                            if (last_frame) state <= PKT_DONE;  // 192 bytes out
                        end
                    end
                end
                PKT_DONE: begin
                    frame_cnt <= '0;
                    state     <= PKT_IDLE;
                end
                default: ;
            endcase
        end
    end

    // the core sees a held byte while it stalls, unless the buffer underran
    a_in_stable: assert property (@(posedge clk) disable iff (!usb_rstn)
        o_in_valid && !i_in_ready && !empty && !i_sof |=> o_in_valid && $stable(o_in_data));

endmodule

`default_nettype wire

//--- pcm_player.sv
/*
 * playback stage
 * buffers deframed frames, plays one per sample tick on the speaker outputs
 */
`default_nettype none

module pcm_player (
    input  wire                               clk,
    input  wire                               usb_rstn,
    input  wire                               i_tick,
    input  wire audio_types_pkg::pcm_frame_t  i_frame,
    input  wire                               i_frame_valid,
    output audio_types_pkg::pcm_sample_t      o_audio_l,
    output audio_types_pkg::pcm_sample_t      o_audio_r
);
    import audio_types_pkg::*;

    pcm_frame_t head;                                    // next frame to play
    logic       empty;
    logic       full;
    logic       push;
    logic       pop;

    assign push = i_frame_valid && !full;                // overflow drops the frame
    assign pop  = i_tick && !empty;                      // underrun holds the output

    pcm_fifo play_fifo (
        .clk         (clk),
        .usb_rstn    (usb_rstn),
        .i_push      (push),
        .i_push_data (i_frame),
        .i_pop       (pop),
        .o_head      (head),
        .o_empty     (empty),
        .o_full      (full)
    );

    // speaker output register, shows the head from the cycle after the tick
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            o_audio_l <= '0;
            o_audio_r <= '0;
        end else if (pop) begin
            o_audio_l <= head.left;
            o_audio_r <= head.right;
        end
    end

endmodule

`default_nettype wire

//--- pcm_fifo.sv
/*
 * show-ahead pcm frame buffer
 * wrap-bit pointers, registered head read from the next read pointer,
 * write-through to the head when a push lands on it
 */
`default_nettype none

module pcm_fifo #(
    parameter int AW = audio_cfg_pkg::FIFO_AW            // depth is 2**AW frames
) (
    input  wire                              clk,
    input  wire                              usb_rstn,
    input  wire                              i_push,
    input  wire audio_types_pkg::pcm_frame_t i_push_data,
    input  wire                              i_pop,
    output audio_types_pkg::pcm_frame_t      o_head,
    output logic                             o_empty,
    output logic                             o_full
);
    audio_types_pkg::pcm_frame_t mem [2**AW];            // maps to block ram

    logic [AW:0] wr_ptr;                                 // msb is the wrap bit
    logic [AW:0] rd_ptr;
    logic [AW:0] rd_ptr_nxt;                             // read pointer after this cycle
    logic        push_ok;
    logic        pop_ok;

    assign o_empty    = (wr_ptr == rd_ptr);
    assign o_full     = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});
    assign push_ok    = i_push && !o_full;               // ignored when full
    assign pop_ok     = i_pop && !o_empty;               // ignored when empty
    assign rd_ptr_nxt = rd_ptr + {{AW{1'b0}}, pop_ok};

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) wr_ptr <= wr_ptr + 1'b1;
            rd_ptr <= rd_ptr_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) mem[wr_ptr[AW-1:0]] <= i_push_data;
    end

    // ------------------------------------------------------------------------
    // head register, valid the cycle after a pop
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (push_ok && (wr_ptr[AW-1:0] == rd_ptr_nxt[AW-1:0])) begin
            o_head <= i_push_data;                       // push into an empty buffer
        end else begin
            o_head <= mem[rd_ptr_nxt[AW-1:0]];
        end
    end

    // callers gate their own requests with the flags
    a_no_push_full: assert property (@(posedge clk) disable iff (!usb_rstn)
        o_full |-> !i_push);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!usb_rstn)
        o_empty |-> !i_pop);

endmodule

`default_nettype wire

//--- pcm_deframer.sv
/*
 * host-to-device deframer
 * packs OUT bytes into pcm frames, low byte first,
 * start-of-frame drops a partial frame
 */
`default_nettype none

module pcm_deframer (
    input  wire                               clk,
    input  wire                               usb_rstn,
    input  wire                               i_sof,
    input  wire audio_types_pkg::out_stream_t i_out,
    output audio_types_pkg::pcm_frame_t       o_frame,
    output logic                              o_frame_valid
);
    import audio_cfg_pkg::*;

    logic [BYTE_IDX_W-1:0] byte_cnt;                     // bytes seen in current frame
    logic                  take;                         // byte accepted this cycle

    assign take = i_out.valid && !i_sof;                 // sof wins over a byte

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            byte_cnt      <= '0;
            o_frame_valid <= 1'b0;
        end else begin
            o_frame_valid <= take && (byte_cnt == BYTE_IDX_W'(BYTES_PER_FRAME - 1));
            if (i_sof) begin
                byte_cnt <= '0;                          // resync to packet start
            end else if (take) begin
                byte_cnt <= byte_cnt + 1'b1;             // wraps after fourth byte
            end
        end
    end

    // new byte enters at the top, so the first byte ends up in bits 7:0
    always_ff @(posedge clk) begin
        if (take) begin
            o_frame <= {i_out.data, o_frame[31:8]};
        end
    end

endmodule

`default_nettype wire

//--- sample_tick_gen.sv
/*
 * 48 kHz sample tick generator
 * one clock wide pulse every CLK_PER_SAMPLE cycles
 */
`default_nettype none

module sample_tick_gen (
    input  wire  clk,
    input  wire  usb_rstn,
    output logic o_tick
);
    import audio_cfg_pkg::*;

    logic [TICK_CNT_W-1:0] cnt;                          // counts 0 .. CLK_PER_SAMPLE-1

    // first pulse lands CLK_PER_SAMPLE cycles after reset release
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (cnt == TICK_CNT_W'(CLK_PER_SAMPLE - 1)) begin
            cnt    <= '0;                                // wrap
            o_tick <= 1'b1;                              // registered tick on wrap
        end else begin
            cnt    <= cnt + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- audio_types_pkg.sv
/*
 * audio streaming types
 * pcm sample and frame, usb payload byte, OUT stream bundle,
 * IN packetizer FSM states
 */
`default_nettype none

package audio_types_pkg;

    typedef logic signed [15:0] pcm_sample_t;           // one channel sample

    // right sits in the high half, matching the byte order on the wire
    typedef struct packed {
        pcm_sample_t right;
        pcm_sample_t left;
    } pcm_frame_t;

    typedef logic [7:0] usb_byte_t;                      // isochronous payload byte

    // host-to-device stream, valid only since iso OUT cannot be stalled
    typedef struct packed {
        logic      valid;
        usb_byte_t data;
    } out_stream_t;

    typedef enum logic [1:0] {
        PKT_IDLE = 2'd0,                                 // waiting for first sof
        PKT_SEND = 2'd1,                                 // streaming packet bytes
        PKT_DONE = 2'd2                                  // packet complete
    } pkt_state_e;

endpackage

`default_nettype wire

//--- audio_cfg_pkg.sv
/*
 * audio streaming constants
 * clock and sample rate, tick divider, frame buffer depth, packet layout
 */
`default_nettype none

package audio_cfg_pkg;

    // ------------------------------------------------------------------------
    // clocking
    // ------------------------------------------------------------------------
    localparam int CLK_HZ         = 60_000_000;           // full-speed core clock
    localparam int SAMPLE_HZ      = 48_000;               // pcm sample rate
    localparam int CLK_PER_SAMPLE = CLK_HZ / SAMPLE_HZ;   // 1250 cycles per tick
    localparam int TICK_CNT_W     = 11;                   // holds 0 .. 1249

    // ------------------------------------------------------------------------
    // buffering and packets
    // ------------------------------------------------------------------------
    localparam int FIFO_AW         = 9;                   // 512 frames per buffer
    localparam int FRAMES_PER_PKT  = 48;                  // one 1 ms usb frame of audio
    localparam int BYTES_PER_FRAME = 4;                   // l lo, l hi, r lo, r hi
    localparam int BYTE_IDX_W      = 2;                   // byte index inside a frame
    localparam int PKT_CNT_W       = 6;                   // frame index inside a packet

endpackage

`default_nettype wire
